// File: design/bru_pkg.sv
// -------------------------------------------------------------------------
// branch op encodings, payload widths and queue depth for the BRU issue
// queue; modules pull these in by import or by scoped name
// -------------------------------------------------------------------------
package bru_pkg;

    localparam int IQ_ENTRIES = 6;

    localparam int PC_WIDTH  = 32;
    localparam int IMM_WIDTH = 20;

    // branch and jump ops handled by the BRU
    typedef enum logic [3:0] {
        JALR   = 4'h0,
        JAL    = 4'h1,
        C_JALR = 4'h2,
        C_JAL  = 4'h3,
        BEQ    = 4'h4,
        BNE    = 4'h5,
        BLT    = 4'h6,
        BGE    = 4'h7,
        BLTU   = 4'h8,
        BGEU   = 4'h9,
        C_BEQZ = 4'ha,
        C_BNEZ = 4'hb,
        LUI    = 4'hc,
        AUIPC  = 4'hd
    } bru_op_e;

endpackage

// File: design/prf_pkg.sv
// -------------------------------------------------------------------------
// physical register file and ROB sizing shared by the issue queue
// low bits of a register number pick its bank, the rest is the upper part
// -------------------------------------------------------------------------
package prf_pkg;

    localparam int LOG_PR_COUNT = 7;

    // one writeback lane per register file bank
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int UPPER_PR_WIDTH     = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

    localparam int LOG_ROB_ENTRIES = 7;

endpackage

// File: design/iq_entry_array.sv
`timescale 1ns/1ps
// -------------------------------------------------------------------------
// entry storage for the collapsing BRU issue queue
// enqueue fills the lowest free slot; on issue, entries from the granted
// slot upward take the entry above, so index order is age order
// -------------------------------------------------------------------------
module iq_entry_array (
    input  logic                                              CLK,
    input  logic                                              nRST,

    input  logic                                              iq_enq_valid,
    input  bru_pkg::bru_op_e                                  iq_enq_op,
    input  logic [bru_pkg::PC_WIDTH-1:0]                      iq_enq_PC,
    input  logic [bru_pkg::IMM_WIDTH-1:0]                     iq_enq_imm20,
    input  logic [prf_pkg::LOG_PR_COUNT-1:0]                  iq_enq_A_PR,
    input  logic                                              iq_enq_A_ready,
    input  logic                                              iq_enq_A_unneeded_or_is_zero,
    input  logic [prf_pkg::LOG_PR_COUNT-1:0]                  iq_enq_B_PR,
    input  logic                                              iq_enq_B_ready,
    input  logic                                              iq_enq_B_unneeded_or_is_zero,
    input  logic [prf_pkg::LOG_PR_COUNT-1:0]                  iq_enq_dest_PR,
    input  logic [prf_pkg::LOG_ROB_ENTRIES-1:0]               iq_enq_ROB_index,

    input  logic [bru_pkg::IQ_ENTRIES-1:0]                    shift_mask,
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                    A_forward_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                    B_forward_by_entry,

    output logic                                              iq_enq_ready,

    output logic [bru_pkg::IQ_ENTRIES-1:0]                    valid_by_entry,
    output bru_pkg::bru_op_e [bru_pkg::IQ_ENTRIES-1:0]        op_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0][bru_pkg::PC_WIDTH-1:0]  PC_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0][bru_pkg::IMM_WIDTH-1:0] imm20_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] A_PR_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0]                    A_ready_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0]                    A_unneeded_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] B_PR_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0]                    B_ready_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0]                    B_unneeded_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] dest_PR_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] ROB_index_by_entry
);

    import bru_pkg::*;

    logic [IQ_ENTRIES-1:0] free_by_entry;
    logic [IQ_ENTRIES-1:0] enq_one_hot;
    logic [IQ_ENTRIES-1:0] keep_by_entry;
    logic [IQ_ENTRIES-1:0] pull_by_entry;
    logic [IQ_ENTRIES-1:0] enq_by_entry;

    // -------------------------------------------------------------------------
    // slot choice

    assign free_by_entry = ~valid_by_entry;
    assign iq_enq_ready  = |free_by_entry;

    // lowest free slot
    assign enq_one_hot = free_by_entry & (~free_by_entry + 1'b1)
        & {IQ_ENTRIES{iq_enq_valid}};

    assign keep_by_entry = valid_by_entry & ~shift_mask;
    assign pull_by_entry = shift_mask & (valid_by_entry >> 1);

    // if the slot below is shifting, the new op drops into it instead
    assign enq_by_entry = (~shift_mask & enq_one_hot)
        | (shift_mask & (enq_one_hot >> 1));

    // -------------------------------------------------------------------------
    // valid and ready state

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_by_entry   <= '0;
            A_ready_by_entry <= '0;
            B_ready_by_entry <= '0;
        end else begin
            valid_by_entry <= keep_by_entry | pull_by_entry | enq_by_entry;
            for (int i = 0; i < IQ_ENTRIES; i++) begin
                if (enq_by_entry[i]) begin
                    A_ready_by_entry[i] <= iq_enq_A_ready;
                    B_ready_by_entry[i] <= iq_enq_B_ready;
                end else if (keep_by_entry[i]) begin
                    A_ready_by_entry[i] <= A_ready_by_entry[i] | A_forward_by_entry[i];
                    B_ready_by_entry[i] <= B_ready_by_entry[i] | B_forward_by_entry[i];
                end
            end
            // forwards follow the entry as it moves down
            for (int i = 0; i < IQ_ENTRIES-1; i++) begin
                if (pull_by_entry[i]) begin
                    A_ready_by_entry[i] <= A_ready_by_entry[i+1] | A_forward_by_entry[i+1];
                    B_ready_by_entry[i] <= B_ready_by_entry[i+1] | B_forward_by_entry[i+1];
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // payload of kept entries simply holds

    always_ff @(posedge CLK) begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (enq_by_entry[i]) begin
                op_by_entry[i]         <= iq_enq_op;
                PC_by_entry[i]         <= iq_enq_PC;
                imm20_by_entry[i]      <= iq_enq_imm20;
                A_PR_by_entry[i]       <= iq_enq_A_PR;
                A_unneeded_by_entry[i] <= iq_enq_A_unneeded_or_is_zero;
                B_PR_by_entry[i]       <= iq_enq_B_PR;
                B_unneeded_by_entry[i] <= iq_enq_B_unneeded_or_is_zero;
                dest_PR_by_entry[i]    <= iq_enq_dest_PR;
                ROB_index_by_entry[i]  <= iq_enq_ROB_index;
            end
        end
        for (int i = 0; i < IQ_ENTRIES-1; i++) begin
            if (pull_by_entry[i]) begin
                op_by_entry[i]         <= op_by_entry[i+1];
                PC_by_entry[i]         <= PC_by_entry[i+1];
                imm20_by_entry[i]      <= imm20_by_entry[i+1];
                A_PR_by_entry[i]       <= A_PR_by_entry[i+1];
                A_unneeded_by_entry[i] <= A_unneeded_by_entry[i+1];
                B_PR_by_entry[i]       <= B_PR_by_entry[i+1];
                B_unneeded_by_entry[i] <= B_unneeded_by_entry[i+1];
                dest_PR_by_entry[i]    <= dest_PR_by_entry[i+1];
                ROB_index_by_entry[i]  <= ROB_index_by_entry[i+1];
            end
        end
    end

endmodule

// File: design/wakeup_match.sv
`timescale 1ns/1ps
// -------------------------------------------------------------------------
// banked wakeup compare for every queue entry
// each source picks the writeback lane of its bank and matches upper bits
// -------------------------------------------------------------------------
module wakeup_match (
    input  logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] A_PR_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] B_PR_by_entry,

    input  logic [prf_pkg::PRF_BANK_COUNT-1:0]                        WB_bus_valid_by_bank,
    input  logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::UPPER_PR_WIDTH-1:0]
                                                                      WB_bus_upper_PR_by_bank,

    output logic [bru_pkg::IQ_ENTRIES-1:0]                            A_forward_by_entry,
    output logic [bru_pkg::IQ_ENTRIES-1:0]                            B_forward_by_entry
);

    import prf_pkg::*;

    // lane lookup by bank bits, then upper compare
    function automatic logic pr_forward(input logic [LOG_PR_COUNT-1:0] pr);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return WB_bus_valid_by_bank[bank]
            & (WB_bus_upper_PR_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    always_comb begin
        for (int i = 0; i < bru_pkg::IQ_ENTRIES; i++) begin
            A_forward_by_entry[i] = pr_forward(A_PR_by_entry[i]);
            B_forward_by_entry[i] = pr_forward(B_PR_by_entry[i]);
        end
    end

endmodule

// File: design/issue_select.sv
`timescale 1ns/1ps
// -------------------------------------------------------------------------
// oldest-first arbiter for the shared issue port
// grants the lowest ready entry and marks it and everything above it for
// the collapse shift
// -------------------------------------------------------------------------
module issue_select (
    input  logic                           issue_ready,
    input  logic [bru_pkg::IQ_ENTRIES-1:0] valid_by_entry,

    input  logic [bru_pkg::IQ_ENTRIES-1:0] A_ready_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0] A_forward_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0] A_unneeded_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0] B_ready_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0] B_forward_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0] B_unneeded_by_entry,

    output logic                           issue_valid,
    output logic [bru_pkg::IQ_ENTRIES-1:0] grant_one_hot,
    output logic [bru_pkg::IQ_ENTRIES-1:0] shift_mask
);

    import bru_pkg::*;

    logic [IQ_ENTRIES-1:0] req_by_entry;

    // both sources usable and port free
    assign req_by_entry = {IQ_ENTRIES{issue_ready}}
        & valid_by_entry
        & (A_ready_by_entry | A_forward_by_entry | A_unneeded_by_entry)
        & (B_ready_by_entry | B_forward_by_entry | B_unneeded_by_entry);

    assign issue_valid = |req_by_entry;

    // isolate lowest set bit
    assign grant_one_hot = req_by_entry & (~req_by_entry + 1'b1);

    // bits at and above the grant, or none without a grant
    assign shift_mask = ~(grant_one_hot - 1'b1);

endmodule

// File: design/issue_mux.sv
`timescale 1ns/1ps
// -------------------------------------------------------------------------
// one-hot issue mux; ORs the granted entry onto the issue outputs and
// raises register file reads for sources not forwarded and not unneeded
// -------------------------------------------------------------------------
module issue_mux (
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                            grant_one_hot,

    input  bru_pkg::bru_op_e [bru_pkg::IQ_ENTRIES-1:0]                op_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][bru_pkg::PC_WIDTH-1:0]     PC_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][bru_pkg::IMM_WIDTH-1:0]    imm20_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] A_PR_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                            A_unneeded_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] B_PR_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                            B_unneeded_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_PR_COUNT-1:0] dest_PR_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] ROB_index_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                            A_forward_by_entry,
    input  logic [bru_pkg::IQ_ENTRIES-1:0]                            B_forward_by_entry,

    output bru_pkg::bru_op_e                                          issue_op,
    output logic [bru_pkg::PC_WIDTH-1:0]                              issue_PC,
    output logic [bru_pkg::IMM_WIDTH-1:0]                             issue_imm20,
    output logic                                                      issue_A_forward,
    output logic                                                      issue_A_unneeded_or_is_zero,
    output logic [prf_pkg::LOG_PRF_BANK_COUNT-1:0]                    issue_A_bank,
    output logic                                                      issue_B_forward,
    output logic                                                      issue_B_unneeded_or_is_zero,
    output logic [prf_pkg::LOG_PRF_BANK_COUNT-1:0]                    issue_B_bank,
    output logic [prf_pkg::LOG_PR_COUNT-1:0]                          issue_dest_PR,
    output logic [prf_pkg::LOG_ROB_ENTRIES-1:0]                       issue_ROB_index,

    output logic                                                      PRF_req_A_valid,
    output logic [prf_pkg::LOG_PR_COUNT-1:0]                          PRF_req_A_PR,
    output logic                                                      PRF_req_B_valid,
    output logic [prf_pkg::LOG_PR_COUNT-1:0]                          PRF_req_B_PR
);

    import bru_pkg::*;
    import prf_pkg::*;

    logic [$bits(bru_op_e)-1:0] op_bits;

    always_comb begin
        op_bits                     = '0;
        issue_PC                    = '0;
        issue_imm20                 = '0;
        issue_A_forward             = 1'b0;
        issue_A_unneeded_or_is_zero = 1'b0;
        issue_A_bank                = '0;
        issue_B_forward             = 1'b0;
        issue_B_unneeded_or_is_zero = 1'b0;
        issue_B_bank                = '0;
        issue_dest_PR               = '0;
        issue_ROB_index             = '0;
        PRF_req_A_valid             = 1'b0;
        PRF_req_A_PR                = '0;
        PRF_req_B_valid             = 1'b0;
        PRF_req_B_PR                = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (grant_one_hot[i]) begin
                op_bits                     |= op_by_entry[i];
                issue_PC                    |= PC_by_entry[i];
                issue_imm20                 |= imm20_by_entry[i];
                issue_A_forward             |= A_forward_by_entry[i];
                issue_A_unneeded_or_is_zero |= A_unneeded_by_entry[i];
                issue_A_bank                |= A_PR_by_entry[i][LOG_PRF_BANK_COUNT-1:0];
                issue_B_forward             |= B_forward_by_entry[i];
                issue_B_unneeded_or_is_zero |= B_unneeded_by_entry[i];
                issue_B_bank                |= B_PR_by_entry[i][LOG_PRF_BANK_COUNT-1:0];
                issue_dest_PR               |= dest_PR_by_entry[i];
                issue_ROB_index             |= ROB_index_by_entry[i];
                // forwarded values come off the bypass, no read needed
                PRF_req_A_valid |= ~A_forward_by_entry[i] & ~A_unneeded_by_entry[i];
                PRF_req_A_PR    |= A_PR_by_entry[i];
                PRF_req_B_valid |= ~B_forward_by_entry[i] & ~B_unneeded_by_entry[i];
                PRF_req_B_PR    |= B_PR_by_entry[i];
            end
        end
        issue_op = bru_op_e'(op_bits);
    end

endmodule

// File: design/bru_iq_top.sv
`timescale 1ns/1ps
// -------------------------------------------------------------------------
// branch resolution unit issue queue, six entries, collapsing
// ops enqueue with a ready level, wake up off the banked writeback bus and
// issue oldest first on one port along with register file read requests
// -------------------------------------------------------------------------
module bru_iq_top (
    input  logic                                   CLK,
    input  logic                                   nRST,

    // enqueue
    input  logic                                   iq_enq_valid,
    input  bru_pkg::bru_op_e                       iq_enq_op,
    input  logic [bru_pkg::PC_WIDTH-1:0]           iq_enq_PC,
    input  logic [bru_pkg::IMM_WIDTH-1:0]          iq_enq_imm20,
    input  logic [prf_pkg::LOG_PR_COUNT-1:0]       iq_enq_A_PR,
    input  logic                                   iq_enq_A_ready,
    input  logic                                   iq_enq_A_unneeded_or_is_zero,
    input  logic [prf_pkg::LOG_PR_COUNT-1:0]       iq_enq_B_PR,
    input  logic                                   iq_enq_B_ready,
    input  logic                                   iq_enq_B_unneeded_or_is_zero,
    input  logic [prf_pkg::LOG_PR_COUNT-1:0]       iq_enq_dest_PR,
    input  logic [prf_pkg::LOG_ROB_ENTRIES-1:0]    iq_enq_ROB_index,
    output logic                                   iq_enq_ready,

    // writeback bus
    input  logic [prf_pkg::PRF_BANK_COUNT-1:0]     WB_bus_valid_by_bank,
    input  logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::UPPER_PR_WIDTH-1:0]
                                                   WB_bus_upper_PR_by_bank,

    // issue
    input  logic                                   issue_ready,
    output logic                                   issue_valid,
    output bru_pkg::bru_op_e                       issue_op,
    output logic [bru_pkg::PC_WIDTH-1:0]           issue_PC,
    output logic [bru_pkg::IMM_WIDTH-1:0]          issue_imm20,
    output logic                                   issue_A_forward,
    output logic                                   issue_A_unneeded_or_is_zero,
    output logic [prf_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
    output logic                                   issue_B_forward,
    output logic                                   issue_B_unneeded_or_is_zero,
    output logic [prf_pkg::LOG_PRF_BANK_COUNT-1:0] issue_B_bank,
    output logic [prf_pkg::LOG_PR_COUNT-1:0]       issue_dest_PR,
    output logic [prf_pkg::LOG_ROB_ENTRIES-1:0]    issue_ROB_index,

    // register file reads
    output logic                                   PRF_req_A_valid,
    output logic [prf_pkg::LOG_PR_COUNT-1:0]       PRF_req_A_PR,
    output logic                                   PRF_req_B_valid,
    output logic [prf_pkg::LOG_PR_COUNT-1:0]       PRF_req_B_PR
);

    import bru_pkg::*;
    import prf_pkg::*;

    // stored entries
    logic [IQ_ENTRIES-1:0]                      valid_by_entry;
    bru_op_e [IQ_ENTRIES-1:0]                   op_by_entry;
    logic [IQ_ENTRIES-1:0][PC_WIDTH-1:0]        PC_by_entry;
    logic [IQ_ENTRIES-1:0][IMM_WIDTH-1:0]       imm20_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]    A_PR_by_entry;
    logic [IQ_ENTRIES-1:0]                      A_ready_by_entry;
    logic [IQ_ENTRIES-1:0]                      A_unneeded_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]    B_PR_by_entry;
    logic [IQ_ENTRIES-1:0]                      B_ready_by_entry;
    logic [IQ_ENTRIES-1:0]                      B_unneeded_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]    dest_PR_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_ROB_ENTRIES-1:0] ROB_index_by_entry;

    // wakeup and select
    logic [IQ_ENTRIES-1:0]                      A_forward_by_entry;
    logic [IQ_ENTRIES-1:0]                      B_forward_by_entry;
    logic [IQ_ENTRIES-1:0]                      grant_one_hot;
    logic [IQ_ENTRIES-1:0]                      shift_mask;

    iq_entry_array i_entries (.*);

    wakeup_match i_wakeup (.*);

    issue_select i_select (.*);

    issue_mux i_mux (.*);

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// testbench clock and reset for the issue queue regression
// 100 ns clock, reset held low for the first 4 cycles
// --------------------------------------------------------------------------
module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // release lands on a falling edge
    initial begin
        nRST = 1'b0;
        #400 nRST = 1'b1;
    end

endmodule

// File: bench/bru_iq_props.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// concurrent checks on the issue port and register file requests,
// bound into the issue queue top level
// --------------------------------------------------------------------------
module bru_iq_props (
    input logic                           CLK,
    input logic                           nRST,
    input logic                           issue_ready,
    input logic                           issue_valid,
    input logic                           PRF_req_A_valid,
    input logic                           PRF_req_B_valid,
    input logic [bru_pkg::IQ_ENTRIES-1:0] grant_one_hot
);

    issue_needs_ready: assert property (@(posedge CLK) disable iff (~nRST)
        issue_valid |-> issue_ready)
        else $error("issue_valid high while issue_ready is low");

    req_a_needs_issue: assert property (@(posedge CLK) disable iff (~nRST)
        PRF_req_A_valid |-> issue_valid)
        else $error("register read for source A without an issue");

    req_b_needs_issue: assert property (@(posedge CLK) disable iff (~nRST)
        PRF_req_B_valid |-> issue_valid)
        else $error("register read for source B without an issue");

    grant_onehot0: assert property (@(posedge CLK) disable iff (~nRST)
        $onehot0(grant_one_hot))
        else $error("more than one entry granted");

    // queue is empty right after reset
    idle_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> ~issue_valid)
        else $error("issue_valid high in the first cycle after reset");

endmodule

bind bru_iq_top bru_iq_props i_props (
    .CLK             (CLK),
    .nRST            (nRST),
    .issue_ready     (issue_ready),
    .issue_valid     (issue_valid),
    .PRF_req_A_valid (PRF_req_A_valid),
    .PRF_req_B_valid (PRF_req_B_valid),
    .grant_one_hot   (grant_one_hot)
);

// File: bench/bru_iq_tb.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------------
// random regression for the BRU issue queue; drives enqueue, writeback
// and issue_ready every cycle and checks all outputs against an in-order
// model of the queue contents
// --------------------------------------------------------------------------
module bru_iq_tb;

    import bru_pkg::*;
    import prf_pkg::*;

    localparam int unsigned SEED = 32'heaba_dcef;
    localparam int NUM_CYCLES     = 2000;
    localparam int DRAIN_CYCLES   = 60;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    typedef struct packed {
        logic [3:0]                 op;
        logic [PC_WIDTH-1:0]        pc;
        logic [IMM_WIDTH-1:0]       imm;
        logic [LOG_PR_COUNT-1:0]    a_pr;
        logic                       a_rdy;
        logic                       a_unn;
        logic [LOG_PR_COUNT-1:0]    b_pr;
        logic                       b_rdy;
        logic                       b_unn;
        logic [LOG_PR_COUNT-1:0]    dest;
        logic [LOG_ROB_ENTRIES-1:0] rob;
    } model_op_t;

    logic CLK, nRST;
    logic iq_enq_valid, iq_enq_ready, issue_ready, issue_valid;
    bru_op_e iq_enq_op, issue_op;
    logic [PC_WIDTH-1:0] iq_enq_PC, issue_PC;
    logic [IMM_WIDTH-1:0] iq_enq_imm20, issue_imm20;
    logic [LOG_PR_COUNT-1:0] iq_enq_A_PR, iq_enq_B_PR, iq_enq_dest_PR, issue_dest_PR;
    logic [LOG_PR_COUNT-1:0] PRF_req_A_PR, PRF_req_B_PR;
    logic [LOG_ROB_ENTRIES-1:0] iq_enq_ROB_index, issue_ROB_index;
    logic iq_enq_A_ready, iq_enq_A_unneeded_or_is_zero;
    logic iq_enq_B_ready, iq_enq_B_unneeded_or_is_zero;
    logic issue_A_forward, issue_A_unneeded_or_is_zero, issue_B_forward;
    logic issue_B_unneeded_or_is_zero, PRF_req_A_valid, PRF_req_B_valid;
    logic [LOG_PRF_BANK_COUNT-1:0] issue_A_bank, issue_B_bank;
    logic [PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
    logic [PRF_BANK_COUNT-1:0][UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank;

    model_op_t model_q[$];
    int cycle_count = 0;
    int issued_count = 0;

    tb_clock_gen i_clk (.CLK(CLK), .nRST(nRST));

    bru_iq_top i_dut (.*);

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h",
                name, actual, expected));
        end
    endtask

    // rebuild each lane's full register number and look for this one
    function automatic logic forwarded(input logic [LOG_PR_COUNT-1:0] pr);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            if (WB_bus_valid_by_bank[b] &&
                {WB_bus_upper_PR_by_bank[b], LOG_PRF_BANK_COUNT'(b)} == pr)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // small register range so wakeups hit often
    task automatic drive_inputs(input logic enq_on);
        iq_enq_valid = enq_on && ($urandom_range(0, 99) < 60);
        iq_enq_op = bru_op_e'($urandom_range(0, 13));
        iq_enq_PC = $urandom;
        iq_enq_imm20 = IMM_WIDTH'($urandom);
        iq_enq_A_PR = LOG_PR_COUNT'($urandom_range(0, 15));
        iq_enq_A_ready = ($urandom_range(0, 3) == 0);
        iq_enq_A_unneeded_or_is_zero = ($urandom_range(0, 4) == 0);
        iq_enq_B_PR = LOG_PR_COUNT'($urandom_range(0, 15));
        iq_enq_B_ready = ($urandom_range(0, 3) == 0);
        iq_enq_B_unneeded_or_is_zero = ($urandom_range(0, 4) == 0);
        iq_enq_dest_PR = LOG_PR_COUNT'($urandom);
        iq_enq_ROB_index = LOG_ROB_ENTRIES'($urandom);
        issue_ready = ~enq_on || ($urandom_range(0, 9) < 7);
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            WB_bus_valid_by_bank[b] = ~enq_on || ($urandom_range(0, 2) == 0);
            WB_bus_upper_PR_by_bank[b] = UPPER_PR_WIDTH'($urandom_range(0, 3));
        end
    endtask

    task automatic check_and_step();
        logic [IQ_ENTRIES-1:0] fa;
        logic [IQ_ENTRIES-1:0] fb;
        logic ga_fwd;
        logic gb_fwd;
        int grant;
        model_op_t g;
        model_op_t e;
        model_op_t next_q[$];
        grant = -1;
        g = '0;
        fa = '0;
        fb = '0;
        for (int i = 0; i < model_q.size(); i++) begin
            fa[i] = forwarded(model_q[i].a_pr);
            fb[i] = forwarded(model_q[i].b_pr);
            if (grant < 0 && issue_ready
                && (model_q[i].a_rdy || fa[i] || model_q[i].a_unn)
                && (model_q[i].b_rdy || fb[i] || model_q[i].b_unn))
                grant = i;
        end
        if (grant >= 0)
            g = model_q[grant];
        ga_fwd = (grant >= 0) ? fa[grant] : 1'b0;
        gb_fwd = (grant >= 0) ? fb[grant] : 1'b0;
        check_value("iq_enq_ready", iq_enq_ready, model_q.size() < IQ_ENTRIES);
        check_value("issue_valid", issue_valid, grant >= 0);
        check_value("issue_op", issue_op, g.op);
        check_value("issue_PC", issue_PC, g.pc);
        check_value("issue_imm20", issue_imm20, g.imm);
        check_value("issue_dest_PR", issue_dest_PR, g.dest);
        check_value("issue_ROB_index", issue_ROB_index, g.rob);
        check_value("issue_A_forward", issue_A_forward, ga_fwd);
        check_value("issue_B_forward", issue_B_forward, gb_fwd);
        check_value("issue_A_unneeded_or_is_zero", issue_A_unneeded_or_is_zero, g.a_unn);
        check_value("issue_B_unneeded_or_is_zero", issue_B_unneeded_or_is_zero, g.b_unn);
        check_value("issue_A_bank", issue_A_bank, g.a_pr % PRF_BANK_COUNT);
        check_value("issue_B_bank", issue_B_bank, g.b_pr % PRF_BANK_COUNT);
        check_value("PRF_req_A_valid", PRF_req_A_valid, grant >= 0 && !ga_fwd && !g.a_unn);
        check_value("PRF_req_B_valid", PRF_req_B_valid, grant >= 0 && !gb_fwd && !g.b_unn);
        check_value("PRF_req_A_PR", PRF_req_A_PR, g.a_pr);
        check_value("PRF_req_B_PR", PRF_req_B_PR, g.b_pr);

        // at the next edge the issued op leaves, wakeups stick, the new op goes last
        for (int i = 0; i < model_q.size(); i++) begin
            if (i != grant) begin
                e = model_q[i];
                e.a_rdy = e.a_rdy | fa[i];
                e.b_rdy = e.b_rdy | fb[i];
                next_q.push_back(e);
            end
        end
        if (iq_enq_valid && model_q.size() < IQ_ENTRIES) begin
            e = {iq_enq_op, iq_enq_PC, iq_enq_imm20, iq_enq_A_PR, iq_enq_A_ready,
                 iq_enq_A_unneeded_or_is_zero, iq_enq_B_PR, iq_enq_B_ready,
                 iq_enq_B_unneeded_or_is_zero, iq_enq_dest_PR, iq_enq_ROB_index};
            next_q.push_back(e);
        end
        if (grant >= 0)
            issued_count++;
        model_q = next_q;
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_failure("timeout: the run did not finish within the cycle limit");
    end

    initial begin
        void'($urandom(SEED));
        drive_inputs(1'b0);
        @(posedge nRST);
        #1;
        check_value("issue_valid", issue_valid, 0);
        check_value("PRF_req_A_valid", PRF_req_A_valid, 0);
        check_value("PRF_req_B_valid", PRF_req_B_valid, 0);
        check_value("iq_enq_ready", iq_enq_ready, 1);

        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge CLK);
            #10;
            drive_inputs(1'b1);
            #70;
            check_and_step();
        end
        // drain with no enqueues and every lane valid
        for (int c = 0; c < DRAIN_CYCLES && model_q.size() > 0; c++) begin
            @(posedge CLK);
            #10;
            drive_inputs(1'b0);
            #70;
            check_and_step();
        end

        if (issued_count > NUM_CYCLES / 4) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_failure("too few ops issued over the run");
        end
    end

endmodule

// File: sim.f
design/bru_pkg.sv
design/prf_pkg.sv
design/iq_entry_array.sv
design/wakeup_match.sv
design/issue_select.sv
design/issue_mux.sv
design/bru_iq_top.sv
bench/tb_clock_gen.sv
bench/bru_iq_props.sv
bench/bru_iq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the BRU issue queue regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module bru_iq_tb -o bru_iq_sim

# a failing run exits nonzero, the verdict comes from the output
output=$(./obj_dir/bru_iq_sim 2>&1) || true
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1
